/* testbench/corr_ctrl_checker.sv */
`timescale 1ns/1ps

module corr_ctrl_checker (
	input logic               clk,
	input logic               rst_n,
	input corr_pkg::wb_req_t  parser_req,
	input corr_pkg::wb_req_t  seq_req,
	input corr_pkg::wb_rsp_t  parser_rsp,
	input corr_pkg::wb_rsp_t  seq_rsp,
	input corr_pkg::wb_req_t  ram_req,
	input corr_pkg::wb_rsp_t  ram_rsp,
	input logic               byte_valid,
	input corr_pkg::capture_t capture,
	input logic               lag_valid,
	input corr_pkg::lag_out_t lag_out,
	input corr_pkg::lag_out_t exp_lag,
	input corr_pkg::capture_t exp_capture
);
	import corr_pkg::*;

	int fail_count = 0; // Read by the testbench after each test.

	////////////////////////////////////////
	// Bus protocol.
	////////////////////////////////////////
	ack_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		ram_rsp.ack |-> ram_req.cyc && ram_req.stb)
	else begin
		fail_count++;
		$error("memory ack raised without cyc and stb");
	end

	// The slave's ack goes to one master, the one whose request it served.
	single_master_ack: assert property (@(posedge clk) disable iff (!rst_n)
		ram_rsp.ack |-> (parser_rsp.ack ^ seq_rsp.ack) &&
			$past(ram_req) == (parser_rsp.ack ? $past(parser_req) : $past(seq_req)))
	else begin
		fail_count++;
		$error("memory ack did not reach exactly the master it served");
	end

	// A master that raises cyc gets its request onto the memory bus.
	parser_reaches_memory: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(parser_req.cyc) |-> ##[1:4] ram_req == parser_req)
	else begin
		fail_count++;
		$error("parser request did not reach the memory");
	end

	seq_reaches_memory: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(seq_req.cyc) |-> ##[1:8] ram_req == seq_req)
	else begin
		fail_count++;
		$error("sequencer request did not reach the memory");
	end

	////////////////////////////////////////
	// Lags and capture flags.
	////////////////////////////////////////
	lag_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
		lag_valid |-> lag_out == exp_lag)
	else begin
		fail_count++;
		$error("mismatch at %0t: line %0d lag %h, expected line %0d lag %h",
			$time, lag_out.line, lag_out.lag, exp_lag.line, exp_lag.lag);
	end

	capture_after_byte: assert property (@(posedge clk) disable iff (!rst_n)
		byte_valid |=> capture == exp_capture)
	else begin
		fail_count++;
		$error("mismatch at %0t: capture %b, expected %b", $time, capture, exp_capture);
	end

	capture_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(rst_n) |-> capture == exp_capture)
	else begin
		fail_count++;
		$error("mismatch at %0t: capture %b after reset, expected %b",
			$time, capture, exp_capture);
	end

endmodule

/* testbench/tb_corr_ctrl.sv */
`timescale 1ns/1ps
`include "corr_macros.svh"

module tb_corr_ctrl;
	import corr_pkg::*;

	// Byte and walk counts per test, in test order.
	localparam int TEST_BYTES = 1 + 32 + 92 + 3 + 5 + 46;
	localparam int TEST_WALKS = 2 + 6 + 1 + 1 + 22;
	localparam int MAX_BIT_CLKS = 3 * `CORR_BAUD_UNIT; // Slowest baud code used is 2.
	localparam int BYTE_CLKS = 11 * MAX_BIT_CLKS;     // Start, 8 data, stop, idle.
	localparam int WALK_CLKS = `CORR_NUM_LINES * 8;
	localparam longint TIMEOUT_NS = 2 * (TEST_BYTES * BYTE_CLKS + TEST_WALKS * WALK_CLKS + 5) * 10;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     serial_in;
	logic     step;
	capture_t capture;
	logic     lag_valid;
	lag_out_t lag_out;

	// Reference model.
	cfg_word_t            m_cfg [`CORR_NUM_LINES];
	logic [19:0]          m_offset [`CORR_NUM_LINES];
	line_t                m_line = '0;
	logic [1:0]           m_field = '0;
	logic [1:0]           m_nib = '0;
	line_t                walk_line = '0;
	logic [20:0]          sum;
	lag_out_t             exp_lag = '0;
	capture_t             exp_capture = '{integrating: 1'b0, external_clock: 1'b0,
		timestamp_reset: 1'b1};
	int                   bit_clks = `CORR_BAUD_UNIT;
	int                   new_bit_clks = `CORR_BAUD_UNIT;
	int                   lag_count = 0;
	int                   steps_issued = 0;
	int                   tb_errors = 0;
	int                   errs_seen = 0;
	int                   tests_ok = 0;
	int                   tests_bad = 0;

	always #5 clk = ~clk;

	corr_ctrl_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.serial_in (serial_in),
		.step      (step),
		.capture   (capture),
		.lag_valid (lag_valid),
		.lag_out   (lag_out)
	);

	bind corr_ctrl_top corr_ctrl_checker i_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.parser_req  (parser_req),
		.seq_req     (seq_req),
		.parser_rsp  (parser_rsp),
		.seq_rsp     (seq_rsp),
		.ram_req     (ram_req),
		.ram_rsp     (ram_rsp),
		.byte_valid  (byte_valid),
		.capture     (capture),
		.lag_valid   (lag_valid),
		.lag_out     (lag_out),
		.exp_lag     (tb_corr_ctrl.exp_lag),
		.exp_capture (tb_corr_ctrl.exp_capture)
	);

	////////////////////////////////////////
	// Lag model, one entry per lag_valid.
	////////////////////////////////////////
	always @(negedge clk) begin
		if (rst_n && lag_valid) begin
			exp_lag.line = walk_line;
			exp_lag.lag = lag_t'(m_cfg[walk_line].start + m_offset[walk_line]);
			sum = {1'b0, m_offset[walk_line]} + 21'(m_cfg[walk_line].incr);
			if (m_cfg[walk_line].len == '0)
				m_offset[walk_line] = '0;
			else if (sum >= {1'b0, m_cfg[walk_line].len})
				m_offset[walk_line] = 20'(sum - {1'b0, m_cfg[walk_line].len}); // Wrap.
			else
				m_offset[walk_line] = sum[19:0];
			walk_line = walk_line + 1'b1;
			lag_count++;
		end
	end

	// Updates the model as the stop bit starts, ahead of byte_valid.
	task automatic apply_command(input logic [7:0] b);
		logic [3:0] d;
		d = b[7:4];
		case (b[3:0])
			`OP_SET_LINE: m_line = line_t'(d);
			`OP_SET_FIELD: begin
				m_field = d[1:0];
				m_nib = d[3:2];
			end
			`OP_WRITE_NIBBLE: begin
				case (m_field)
					2'd0: m_cfg[m_line].start[int'(m_nib) * 4 +: 4] = d;
					2'd1: m_cfg[m_line].len[int'(m_nib) * 4 +: 4] = d;
					2'd2: if (m_nib < 2'd3) m_cfg[m_line].incr[int'(m_nib) * 4 +: 4] = d;
					default: ;
				endcase
			end
			`OP_CLEAR: m_cfg[m_line] = '0;
			`OP_SET_BAUD: new_bit_clks = (int'(d) + 1) * `CORR_BAUD_UNIT;
			`OP_CAPTURE: exp_capture = '{integrating: d[0], external_clock: d[1],
				timestamp_reset: d[2]};
			default: ;
		endcase
	endtask

	// Start bit, 8 data bits LSB first, stop bit, one idle bit.
	task automatic send_byte(input logic [7:0] b, input bit with_step);
		logic [10:0] frame;
		frame = {2'b11, b, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(negedge clk);
			serial_in = frame[i];
			if (i == 9) begin
				apply_command(b);
				if (with_step) begin
					step = 1'b1; // Walk overlaps this byte's bus cycles.
					steps_issued++;
				end
			end
			repeat (bit_clks - 1) begin
				@(negedge clk);
				step = 1'b0;
			end
		end
		bit_clks = new_bit_clks;
	endtask

	task automatic send_cmd(input logic [3:0] op, input logic [3:0] d);
		send_byte({d, op}, 1'b0);
	endtask

	task automatic write_nibble(input field_t f, input logic [1:0] nib,
		input logic [3:0] val, input bit with_step);
		send_cmd(`OP_SET_FIELD, {nib, 2'(f)});
		send_byte({val, `OP_WRITE_NIBBLE}, with_step);
	endtask

	task automatic program_line(input line_t l, input logic [15:0] s, input logic [15:0] ln,
		input logic [11:0] inc, input bit with_step);
		send_cmd(`OP_SET_LINE, 4'(l));
		for (int n = 0; n < 4; n++)
			write_nibble(FIELD_START, 2'(n), s[n * 4 +: 4], with_step);
		for (int n = 0; n < 4; n++)
			write_nibble(FIELD_LEN, 2'(n), ln[n * 4 +: 4], with_step);
		for (int n = 0; n < 3; n++)
			write_nibble(FIELD_INCR, 2'(n), inc[n * 4 +: 4], with_step);
	endtask

	task automatic wait_walks();
		int n;
		n = 0;
		while (lag_count < 16 * steps_issued && n < 2 * WALK_CLKS) begin
			@(negedge clk);
			n++;
		end
		if (lag_count != 16 * steps_issued) begin
			tb_errors++;
			$display("lag walk did not complete: %0d lags seen, %0d expected",
				lag_count, 16 * steps_issued);
		end
	endtask

	task automatic step_and_wait(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			step = 1'b1;
			steps_issued++;
			@(negedge clk);
			step = 1'b0;
			wait_walks();
		end
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = i_dut.i_checker.fail_count + tb_errors;
		if (errs == errs_seen) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", name, errs - errs_seen);
		end
		errs_seen = errs;
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		line_t       prog_lines [4];
		logic [15:0] s;
		logic [15:0] ln;
		logic [11:0] inc;
		prog_lines = '{4'd1, 4'd4, 4'd9, 4'd12};
		void'($urandom(78818));
		for (int i = 0; i < `CORR_NUM_LINES; i++)
			m_offset[i] = '0;
		rst_n = 1'b0;
		serial_in = 1'b1;
		step = 1'b0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;

		send_cmd(`OP_CAPTURE, 4'b0011);
		finish_test("capture flags");

		for (int l = 0; l < `CORR_NUM_LINES; l++) begin
			send_cmd(`OP_SET_LINE, 4'(l));
			send_cmd(`OP_CLEAR, 4'd0);
		end
		step_and_wait(2);
		finish_test("clear and step");

		for (int i = 0; i < 4; i++) begin
			s = 16'($urandom);
			ln = (i == 2) ? 16'd0 : 16'(1 + $urandom % 200); // Line 9 gets zero length.
			inc = 12'($urandom % 300);
			program_line(prog_lines[i], s, ln, inc, 1'b0);
		end
		step_and_wait(6);
		finish_test("random configs");

		send_cmd(`OP_SET_LINE, 4'd1);
		write_nibble(FIELD_INCR, 2'd3, 4'hf, 1'b0); // Beyond the 12-bit increment.
		step_and_wait(1);
		finish_test("nibble out of range");

		send_cmd(`OP_SET_BAUD, 4'd2);
		send_cmd(`OP_CAPTURE, 4'b0101);
		send_cmd(`OP_SET_LINE, 4'd2);
		write_nibble(FIELD_START, 2'd0, 4'ha, 1'b0);
		step_and_wait(1);
		finish_test("baud change");

		// Lines near the end of the walk are read after each write lands.
		for (int l = 14; l < 16; l++)
			program_line(line_t'(l), 16'($urandom), 16'(1 + $urandom % 500),
				12'($urandom), 1'b1);
		wait_walks();
		finish_test("steps during writes");

		$display("%0d tests ok, %0d tests failed, %0d errors", tests_ok, tests_bad, errs_seen);
		if (tests_bad == 0 && errs_seen == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* verilog/cmd_parser.sv */
`timescale 1ns/1ps
`include "corr_macros.svh"

module cmd_parser (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [7:0]         rx_byte,
	input  logic               byte_valid,
	output logic [3:0]         baud_code,
	output corr_pkg::capture_t capture,
	output corr_pkg::wb_req_t  wb_req,
	input  corr_pkg::wb_rsp_t  wb_rsp
);
	import corr_pkg::*;

	logic [3:0]            opcode;
	logic [3:0]            data;
	parser_state_t         state;
	line_t                 line;
	field_t                field;
	logic [1:0]            nib_idx;
	logic [3:0]            nib_val;
	logic                  nib_ok;
	logic                  cyc;
	logic                  we;
	line_t                 adr;
	cfg_word_t             wdat;
	cfg_word_t             merged;
	logic [`CORR_LEN_W-1:0] incr_wide;

	assign opcode = rx_byte[3:0];
	assign data = rx_byte[7:4];

	// stb follows cyc through both halves of a read-modify-write.
	assign wb_req = '{cyc: cyc, stb: cyc, we: we, adr: adr, dat: wdat};

	function automatic logic [`CORR_LEN_W-1:0] put_nibble(
		input logic [`CORR_LEN_W-1:0] value,
		input logic [1:0]             idx,
		input logic [3:0]             nib
	);
		logic [`CORR_LEN_W-1:0] res;
		res = value;
		res[idx*4 +: 4] = nib;
		return res;
	endfunction

	always_comb begin
		case (field)
			FIELD_START: nib_ok = (int'(nib_idx) * 4) < `CORR_START_W;
			FIELD_LEN:   nib_ok = (int'(nib_idx) * 4) < `CORR_LEN_W;
			FIELD_INCR:  nib_ok = (int'(nib_idx) * 4) < `CORR_INCR_W;
			default:     nib_ok = 1'b0;
		endcase
	end

	// New word from the read data.
	always_comb begin
		merged = wb_rsp.dat;
		incr_wide = put_nibble(`CORR_LEN_W'(wb_rsp.dat.incr), nib_idx, nib_val);
		case (field)
			FIELD_START: merged.start = put_nibble(wb_rsp.dat.start, nib_idx, nib_val);
			FIELD_LEN:   merged.len = put_nibble(wb_rsp.dat.len, nib_idx, nib_val);
			FIELD_INCR:  merged.incr = incr_wide[`CORR_INCR_W-1:0];
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= P_IDLE;
			line <= '0;
			field <= FIELD_START;
			nib_idx <= '0;
			baud_code <= '0;
			capture <= '{integrating: 1'b0, external_clock: 1'b0, timestamp_reset: 1'b1};
			cyc <= 1'b0;
			we <= 1'b0;
		end else begin
			////////////////////////////////////////
			// Register-only commands.
			////////////////////////////////////////
			if (byte_valid) begin
				case (opcode)
					`OP_SET_LINE: line <= line_t'(data);
					`OP_SET_FIELD: begin
						field <= field_t'(data[1:0]); // Code 3 selects nothing.
						nib_idx <= data[3:2];
					end
					`OP_SET_BAUD: baud_code <= data;
					`OP_CAPTURE: capture <= '{integrating: data[0],
						external_clock: data[1], timestamp_reset: data[2]};
					default: ;
				endcase
			end

			////////////////////////////////////////
			// Bus cycles.
			////////////////////////////////////////
			case (state)
				P_IDLE: begin
					if (byte_valid && opcode == `OP_CLEAR) begin
						cyc <= 1'b1;
						we <= 1'b1;
						state <= P_WRITE;
					end else if (byte_valid && opcode == `OP_WRITE_NIBBLE && nib_ok) begin
						cyc <= 1'b1;
						we <= 1'b0;
						state <= P_READ;
					end
				end
				P_READ: begin
					if (wb_rsp.ack) begin
						we <= 1'b1; // cyc stays up, nothing can slip in.
						state <= P_WRITE;
					end
				end
				P_WRITE: begin
					if (wb_rsp.ack) begin
						cyc <= 1'b0;
						we <= 1'b0;
						state <= P_IDLE;
					end
				end
				default: state <= P_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == P_IDLE && byte_valid) begin
			adr <= line;
			nib_val <= data;
			wdat <= '0; // Clear writes this as is.
		end
		if (state == P_READ && wb_rsp.ack)
			wdat <= merged;
	end

endmodule

/* verilog/corr_ctrl_top.sv */
`timescale 1ns/1ps

module corr_ctrl_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               serial_in,
	input  logic               step,
	output corr_pkg::capture_t capture,
	output logic               lag_valid,
	output corr_pkg::lag_out_t lag_out
);
	import corr_pkg::*;

	logic [7:0] rx_byte;
	logic       byte_valid;
	logic [3:0] baud_code;

	wb_req_t parser_req;
	wb_rsp_t parser_rsp;
	wb_req_t seq_req;
	wb_rsp_t seq_rsp;
	wb_req_t ram_req;
	wb_rsp_t ram_rsp;

	uart_rx i_uart_rx (
		.clk        (clk),
		.rst_n      (rst_n),
		.serial_in  (serial_in),
		.baud_code  (baud_code),
		.rx_byte    (rx_byte),
		.byte_valid (byte_valid)
	);

	cmd_parser i_cmd_parser (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_byte    (rx_byte),
		.byte_valid (byte_valid),
		.baud_code  (baud_code),
		.capture    (capture),
		.wb_req     (parser_req),
		.wb_rsp     (parser_rsp)
	);

	lag_sequencer i_lag_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.step      (step),
		.wb_req    (seq_req),
		.wb_rsp    (seq_rsp),
		.lag_valid (lag_valid),
		.lag_out   (lag_out)
	);

	// Parser on m0 wins ties.
	wb_arbiter i_wb_arbiter (
		.clk    (clk),
		.rst_n  (rst_n),
		.m0_req (parser_req),
		.m1_req (seq_req),
		.m0_rsp (parser_rsp),
		.m1_rsp (seq_rsp),
		.s_req  (ram_req),
		.s_rsp  (ram_rsp)
	);

	line_config_ram i_line_config_ram (
		.clk    (clk),
		.rst_n  (rst_n),
		.wb_req (ram_req),
		.wb_rsp (ram_rsp)
	);

endmodule

/* verilog/corr_macros.svh */
`ifndef CORR_MACROS_SVH
`define CORR_MACROS_SVH

// Line count and per-line field widths.
`define CORR_NUM_LINES 16
`define CORR_START_W 20
`define CORR_LEN_W 20
`define CORR_INCR_W 12

// Clocks per bit are (baud code + 1) times this unit.
`define CORR_BAUD_UNIT 4

////////////////////////////////////////
// Command opcodes, low nibble of a byte.
////////////////////////////////////////
`define OP_CLEAR 4'd0
`define OP_SET_LINE 4'd1
`define OP_SET_FIELD 4'd2
`define OP_WRITE_NIBBLE 4'd3
`define OP_SET_BAUD 4'd4
`define OP_CAPTURE 4'd13

`endif

/* verilog/corr_pkg.sv */
`include "corr_macros.svh"

package corr_pkg;

	typedef logic [$clog2(`CORR_NUM_LINES)-1:0] line_t;
	typedef logic [`CORR_START_W-1:0] lag_t;

	// One configuration memory word.
	typedef struct packed {
		logic [`CORR_START_W-1:0] start;
		logic [`CORR_LEN_W-1:0]   len;
		logic [`CORR_INCR_W-1:0]  incr;
	} cfg_word_t;

	typedef enum logic [1:0] {FIELD_START, FIELD_LEN, FIELD_INCR} field_t;

	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		line_t     adr;
		cfg_word_t dat;
	} wb_req_t;

	typedef struct packed {
		logic      ack;
		cfg_word_t dat;
	} wb_rsp_t;

	typedef struct packed {
		logic integrating;
		logic external_clock;
		logic timestamp_reset;
	} capture_t;

	typedef struct packed {
		line_t line;
		lag_t  lag;
	} lag_out_t;

	typedef enum logic [1:0] {P_IDLE, P_READ, P_WRITE} parser_state_t;
	typedef enum logic [1:0] {S_IDLE, S_READ, S_EMIT} seq_state_t;

endpackage

/* verilog/lag_sequencer.sv */
`timescale 1ns/1ps
`include "corr_macros.svh"

module lag_sequencer (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               step,
	output corr_pkg::wb_req_t  wb_req,
	input  corr_pkg::wb_rsp_t  wb_rsp,
	output logic               lag_valid,
	output corr_pkg::lag_out_t lag_out
);
	import corr_pkg::*;

	seq_state_t             state;
	line_t                  line;
	logic                   cyc;
	logic                   pending; // One step queued behind the running walk.
	logic [`CORR_LEN_W-1:0] offset [`CORR_NUM_LINES];
	cfg_word_t              cfg;
	logic [`CORR_LEN_W:0]   sum;
	logic [`CORR_LEN_W:0]   diff;
	logic [`CORR_LEN_W-1:0] next_offset;

	// One read cycle per line, so the parser can get in between lines.
	assign wb_req = '{cyc: cyc, stb: cyc, we: 1'b0, adr: line, dat: '0};

	always_comb begin
		sum = {1'b0, offset[line]} + (`CORR_LEN_W + 1)'(cfg.incr);
		diff = sum - {1'b0, cfg.len};
		if (cfg.len == '0)
			next_offset = '0;
		else if (sum >= {1'b0, cfg.len})
			next_offset = diff[`CORR_LEN_W-1:0]; // Wrap.
		else
			next_offset = sum[`CORR_LEN_W-1:0];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			line <= '0;
			cyc <= 1'b0;
			pending <= 1'b0;
			lag_valid <= 1'b0;
			for (int i = 0; i < `CORR_NUM_LINES; i++)
				offset[i] <= '0;
		end else begin
			lag_valid <= 1'b0;
			if (step && state != S_IDLE)
				pending <= 1'b1;
			case (state)
				S_IDLE: begin
					if (step || pending) begin
						pending <= 1'b0;
						line <= '0;
						cyc <= 1'b1;
						state <= S_READ;
					end
				end
				S_READ: begin
					if (wb_rsp.ack) begin
						cyc <= 1'b0;
						lag_valid <= 1'b1;
						state <= S_EMIT;
					end
				end
				S_EMIT: begin
					offset[line] <= next_offset;
					if (line == line_t'(`CORR_NUM_LINES - 1)) begin
						state <= S_IDLE; // Walk done.
					end else begin
						line <= line + 1'b1;
						cyc <= 1'b1;
						state <= S_READ;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_READ && wb_rsp.ack) begin
			cfg <= wb_rsp.dat;
			lag_out <= '{line: line, lag: wb_rsp.dat.start + offset[line]};
		end
	end

endmodule

/* verilog/line_config_ram.sv */
`timescale 1ns/1ps
`include "corr_macros.svh"

module line_config_ram (
	input  logic              clk,
	input  logic              rst_n,
	input  corr_pkg::wb_req_t wb_req,
	output corr_pkg::wb_rsp_t wb_rsp
);
	import corr_pkg::*;

	cfg_word_t mem [`CORR_NUM_LINES];
	cfg_word_t rd_dat;
	logic      ack;
	logic      hit;

	// No second ack while stb stays up across the acked cycle.
	assign hit = wb_req.cyc & wb_req.stb & ~ack;

	assign wb_rsp = '{ack: ack, dat: rd_dat};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ack <= 1'b0;
		else
			ack <= hit;
	end

	always_ff @(posedge clk) begin
		if (hit) begin
			if (wb_req.we)
				mem[wb_req.adr] <= wb_req.dat;
			rd_dat <= mem[wb_req.adr]; // Valid with ack.
		end
	end

endmodule

/* verilog/uart_rx.sv */
`timescale 1ns/1ps
`include "corr_macros.svh"

module uart_rx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       serial_in,
	input  logic [3:0] baud_code,
	output logic [7:0] rx_byte,
	output logic       byte_valid
);

	logic [2:0] sync;     // [1] is the synchronized line, [2] its previous value.
	logic       rx_line;
	logic       start_edge;
	logic [7:0] period;
	logic       busy;
	logic [7:0] bit_clks; // Bit time latched at the start edge.
	logic [7:0] cnt;
	logic [3:0] bit_idx;  // 0 start bit, 1..8 data, 9 stop.
	logic [7:0] shift;

	assign rx_line = sync[1];
	assign start_edge = sync[2] & ~sync[1];
	assign period = (8'(baud_code) + 8'd1) * 8'(`CORR_BAUD_UNIT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync <= 3'b111;
			busy <= 1'b0;
			bit_clks <= '0;
			cnt <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
		end else begin
			sync <= {sync[1:0], serial_in};
			byte_valid <= 1'b0;
			if (!busy) begin
				if (start_edge) begin
					busy <= 1'b1;
					bit_clks <= period;
					cnt <= {1'b0, period[7:1]} - 8'd1; // First sample at mid start bit.
					bit_idx <= '0;
				end
			end else if (cnt != '0) begin
				cnt <= cnt - 8'd1;
			end else begin
				cnt <= bit_clks - 8'd1;
				bit_idx <= bit_idx + 4'd1;
				if (bit_idx == 4'd0 && rx_line)
					busy <= 1'b0; // Glitch, not a start bit.
				if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					byte_valid <= rx_line; // Bad stop bit drops the byte.
				end
			end
		end
	end

	// LSB first.
	always_ff @(posedge clk) begin
		if (busy && cnt == '0) begin
			if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
				shift <= {rx_line, shift[7:1]};
			if (bit_idx == 4'd9)
				rx_byte <= shift;
		end
	end

endmodule

/* verilog/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
	input  logic              clk,
	input  logic              rst_n,
	input  corr_pkg::wb_req_t m0_req,
	input  corr_pkg::wb_req_t m1_req,
	output corr_pkg::wb_rsp_t m0_rsp,
	output corr_pkg::wb_rsp_t m1_rsp,
	output corr_pkg::wb_req_t s_req,
	input  corr_pkg::wb_rsp_t s_rsp
);

	logic granted;
	logic owner;     // 0 parser, 1 sequencer.
	logic owner_cyc;

	assign owner_cyc = owner ? m1_req.cyc : m0_req.cyc;

	// Grant holds until the owner drops cyc.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			granted <= 1'b0;
			owner <= 1'b0;
		end else if (!granted || !owner_cyc) begin
			if (m0_req.cyc) begin
				granted <= 1'b1;
				owner <= 1'b0;
			end else if (m1_req.cyc) begin
				granted <= 1'b1;
				owner <= 1'b1;
			end else begin
				granted <= 1'b0;
			end
		end
	end

	always_comb begin
		s_req = owner ? m1_req : m0_req;
		if (!granted) begin
			s_req.cyc = 1'b0;
			s_req.stb = 1'b0;
		end
		m0_rsp = s_rsp;
		m1_rsp = s_rsp;
		m0_rsp.ack = s_rsp.ack & granted & ~owner;
		m1_rsp.ack = s_rsp.ack & granted & owner; // Only the owner sees ack.
	end

endmodule

/* vlog.f */
+incdir+verilog
verilog/corr_pkg.sv
verilog/uart_rx.sv
verilog/cmd_parser.sv
verilog/lag_sequencer.sv
verilog/wb_arbiter.sv
verilog/line_config_ram.sv
verilog/corr_ctrl_top.sv
testbench/corr_ctrl_checker.sv
testbench/tb_corr_ctrl.sv
